// File: byteRam.sv
`timescale 1ns/1ps

module byteRam (
	input logic clk,
	input logic [memMapPkg::wordAddrWidth-1:0] address,
	input logic writeEnable,
	input logic [3:0] byteMask,
	input memBusPkg::memWord writeData,
	output memBusPkg::memWord readData
);
	import memMapPkg::*;
	import memBusPkg::*;

	// holds program and data together
	memWord mem [memWords];

	// preload of the program image
	initial begin
		$readmemh(initFile, mem);
	end

	always_ff @(posedge clk) begin
		// only masked lanes change
		if (writeEnable) begin
			for (int lane = 0; lane < 4; lane++) begin
				if (byteMask[lane]) begin
					mem[address].bytes[lane] <= writeData.bytes[lane];
				end
			end
		end
		// registered read returns the old word on a same-address write
		readData <= mem[address];
	end

	// the steering logic must drop the mask whenever it drops the write
	maskOnlyOnWrite: assert property (@(posedge clk) !writeEnable |-> byteMask == 4'b0000)
		else $error("byteRam: mask %b with write disabled", byteMask);

endmodule

// File: dataMemory.sv
`timescale 1ns/1ps

module dataMemory (
	input logic clk,
	input logic reset,
	input logic [memMapPkg::byteAddrWidth-1:0] pc,
	input memBusPkg::busCmd cmd,
	output logic dataSlot,
	output memBusPkg::busResult result,
	output memBusPkg::fetchPort fetch
);
	import memMapPkg::*;
	import memBusPkg::*;

	// single RAM port
	logic [wordAddrWidth-1:0] ramAddress;
	logic ramWriteEnable;
	logic [3:0] ramMask;
	memWord ramWriteData;
	memWord ramReadData;

	// store qualifier before the alignment check
	logic storeWrite;
	logic misaligned;

	// data slot request kept for the result cycle
	accessSize loadSize;
	logic [1:0] loadOffset;
	logic loadUnsigned;
	logic loadIsRead;
	logic resultValid;
	logic resultError;
	logic [31:0] loadData;

	// fetch side holds the last fetched word
	logic fetchValid;
	logic [31:0] instruction;

	// fetch slot and data slot alternate on every edge
	always_ff @(posedge clk) begin
		if (reset) begin
			dataSlot <= 1'b0;
		end else begin
			dataSlot <= ~dataSlot;
		end
	end

	// port steering
	// pc word in the fetch slot and bus word in the data slot
	assign ramAddress = dataSlot ? cmd.address[byteAddrWidth-1:2] : pc[byteAddrWidth-1:2];
	assign storeWrite = dataSlot && cmd.valid && cmd.write;
	// misaligned stores never reach the RAM
	assign ramWriteEnable = storeWrite && !misaligned;

	storeAligner aligner (
		.size(cmd.size),
		.offset(cmd.address[1:0]),
		.write(storeWrite),
		.storeData(cmd.writeData),
		.byteMask(ramMask),
		.laneData(ramWriteData),
		.misaligned(misaligned)
	);

	byteRam ram (
		.clk(clk),
		.address(ramAddress),
		.writeEnable(ramWriteEnable),
		.byteMask(ramMask),
		.writeData(ramWriteData),
		.readData(ramReadData)
	);

	// one-cycle strobes
	always_ff @(posedge clk) begin
		if (reset) begin
			fetchValid <= 1'b0;
			resultValid <= 1'b0;
			resultError <= 1'b0;
		end else begin
			fetchValid <= dataSlot;
			resultValid <= dataSlot && cmd.valid;
			resultError <= dataSlot && cmd.valid && misaligned;
		end
	end

	// at the end of the data slot the RAM still shows the fetch word
	always_ff @(posedge clk) begin
		if (dataSlot) begin
			instruction <= ramReadData.word;
			loadSize <= cmd.size;
			loadOffset <= cmd.address[1:0];
			loadUnsigned <= cmd.unsignedLoad;
			loadIsRead <= cmd.valid && !cmd.write;
		end
	end

	// lane pick on the word read during the data slot
	loadExtractor extractor (
		.word(ramReadData),
		.size(loadSize),
		.offset(loadOffset),
		.unsignedLoad(loadUnsigned),
		.loadData(loadData)
	);

	assign result.valid = resultValid;
	assign result.error = resultError;
	// stores and errors answer with zero
	assign result.readData = (resultValid && loadIsRead && !resultError) ? loadData : '0;

	assign fetch.valid = fetchValid;
	assign fetch.instruction = instruction;

	// requester may only drive the bus while dataSlot is high
	cmdInDataSlot: assert property (@(posedge clk) disable iff (reset) cmd.valid |-> dataSlot)
		else $error("dataMemory: cmd.valid outside the data slot");

	// fetch side must present a word address
	pcAligned: assert property (@(posedge clk) disable iff (reset)
			!dataSlot |-> pc[1:0] == 2'b00)
		else $error("dataMemory: pc %h not word aligned", pc);

endmodule

// File: flist.f
memMapPkg.sv
memBusPkg.sv
byteRam.sv
storeAligner.sv
loadExtractor.sv
dataMemory.sv
memorySubsystem.sv
memorySubsystemTb.sv

// File: loadExtractor.sv
`timescale 1ns/1ps

module loadExtractor (
	input memBusPkg::memWord word,
	input memBusPkg::accessSize size,
	input logic [1:0] offset,
	input logic unsignedLoad,
	output logic [31:0] loadData
);
	import memBusPkg::*;

	// top bit of the picked lane or zero for unsigned loads
	logic signBit;

	always_comb begin
		signBit = 1'b0;
		unique case (size)
			sizeByte: begin
				// lb/lbu with the lane chosen by both offset bits
				signBit = word.bytes[offset][7] & ~unsignedLoad;
				loadData = {{24{signBit}}, word.bytes[offset]};
			end
			sizeHalf: begin
				// lh/lhu takes the upper half when offset[1] is set
				signBit = word.halves[offset[1]][15] & ~unsignedLoad;
				loadData = {{16{signBit}}, word.halves[offset[1]]};
			end
			default: begin
				// lw has nothing to extend
				loadData = word.word;
			end
		endcase
	end

endmodule

// File: memBusPkg.sv
package memBusPkg;

	// access width in the same coding as funct3[1:0] of loads and stores
	typedef enum logic [1:0] {
		sizeByte = 2'd0,
		sizeHalf = 2'd1,
		sizeWord = 2'd2
	} accessSize;

	// one RAM word
	// little-endian with lane 0 at the lowest byte address
	typedef union packed {
		logic [31:0] word;
		logic [1:0][15:0] halves;
		logic [3:0][7:0] bytes;
	} memWord;

	// load/store request sampled in the data slot only
	typedef struct packed {
		logic valid;
		logic write;
		accessSize size;
		// lbu/lhu
		logic unsignedLoad;
		logic [memMapPkg::byteAddrWidth-1:0] address;
		// store value sits in the low lanes
		memWord writeData;
	} busCmd;

	// one-cycle strobe after the data slot
	// stores answer too with readData zero
	typedef struct packed {
		logic valid;
		logic error;
		logic [31:0] readData;
	} busResult;

	// instruction side
	// valid for one cycle and instruction held for the frame
	typedef struct packed {
		logic valid;
		logic [31:0] instruction;
	} fetchPort;

endpackage

// File: memMapPkg.sv
package memMapPkg;

	// byte address seen on the bus and by the fetch side
	localparam int byteAddrWidth = 14;

	// low two bits pick the lane, the rest pick the word
	localparam int wordAddrWidth = byteAddrWidth - 2;

	// one word per word address
	localparam int memWords = 1 << wordAddrWidth;

	// program image loaded at elaboration
	// reset never touches it
	localparam string initFile = "program.hex";

endpackage

// File: memorySubsystem.sv
`timescale 1ns/1ps

module memorySubsystem (
	input logic clk,
	input logic reset,
	input logic [memMapPkg::byteAddrWidth-1:0] pc,
	input memBusPkg::busCmd cmd,
	output logic dataSlot,
	output memBusPkg::busResult result,
	output memBusPkg::fetchPort fetch
);

	// fetch and load/store share one RAM port
	// core side sees dataSlot to know when it may drive cmd
	dataMemory memory (
		.clk(clk),
		.reset(reset),
		.pc(pc),
		.cmd(cmd),
		.dataSlot(dataSlot),
		.result(result),
		.fetch(fetch)
	);

	// later clients hang off here

endmodule

// File: memorySubsystemTb.sv
`timescale 1ns/1ps

module memorySubsystemTb;
	import memMapPkg::*;
	import memBusPkg::*;

	// tests run about 150 cycles including slot waits
	localparam int maxCycles = 400;

	logic clk;
	logic reset;
	logic [byteAddrWidth-1:0] pc;
	busCmd cmd;
	logic dataSlot;
	busResult result;
	fetchPort fetch;

	// expected memory image that follows every store
	logic [31:0] model [memWords];
	int cycleCount = 0;

	memorySubsystem dut (
		.clk(clk),
		.reset(reset),
		.pc(pc),
		.cmd(cmd),
		.dataSlot(dataSlot),
		.result(result),
		.fetch(fetch)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount == maxCycles) begin
			failRun("timeout: the tests did not finish within the cycle limit");
		end
	end

	task automatic failRun(input string line);
		$display("%s", line);
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkResult(input busResult got, input busResult exp, input string what);
		if (got !== exp) begin
			failRun($sformatf("MISMATCH at %0t: %s, got %b/%b/%h, expected %b/%b/%h", $time,
				what, got.valid, got.error, got.readData, exp.valid, exp.error, exp.readData));
		end
	endtask

	task automatic checkFetch(input fetchPort got, input fetchPort exp, input string what);
		if (got !== exp) begin
			failRun($sformatf("MISMATCH at %0t: %s, got %b/%h, expected %b/%h", $time, what,
				got.valid, got.instruction, exp.valid, exp.instruction));
		end
	endtask

	// half at an odd offset or word at any nonzero offset
	function automatic logic isMisaligned(input accessSize size, input logic [1:0] off);
		return (size == sizeHalf && off[0]) || (size == sizeWord && off != 2'b00);
	endfunction

	// little-endian lane merge by shifting the low bits of data
	function automatic logic [31:0] mergeStore(input logic [31:0] old, input accessSize size,
			input logic [1:0] off, input logic [31:0] data);
		logic [31:0] laneMask;
		logic [4:0] shift;
		shift = {off, 3'b000};
		case (size)
			sizeByte: laneMask = 32'h0000_00ff << shift;
			sizeHalf: laneMask = 32'h0000_ffff << shift;
			default: laneMask = 32'hffff_ffff;
		endcase
		return (old & ~laneMask) | ((data << shift) & laneMask);
	endfunction

	function automatic logic [31:0] extendLoad(input logic [31:0] w, input accessSize size,
			input logic [1:0] off, input logic uns);
		logic [31:0] lane;
		lane = w >> {off, 3'b000};
		case (size)
			sizeByte: return uns ? {24'h0, lane[7:0]} : {{24{lane[7]}}, lane[7:0]};
			sizeHalf: return uns ? {16'h0, lane[15:0]} : {{16{lane[15]}}, lane[15:0]};
			default: return w;
		endcase
	endfunction

	function automatic busCmd makeCmd(input logic write, input accessSize size, input logic uns,
			input logic [byteAddrWidth-1:0] addr, input logic [31:0] data);
		busCmd c;
		c.valid = 1'b1;
		c.write = write;
		c.size = size;
		c.unsignedLoad = uns;
		c.address = addr;
		c.writeData.word = data;
		return c;
	endfunction

	// cmd present for exactly the data slot and result taken the cycle after
	task automatic busAccess(input busCmd c, output busResult r);
		@(negedge clk);
		while (dataSlot) @(negedge clk);
		@(posedge clk);
		cmd <= c;
		@(posedge clk);
		cmd <= '0;
		@(negedge clk);
		r = result;
		// strobe gone again in the following data slot
		@(negedge clk);
		checkResult(result, '0, "result strobe after its one cycle");
	endtask

	task automatic storeTo(input logic [byteAddrWidth-1:0] addr, input accessSize size,
			input logic [31:0] data);
		busResult got;
		logic bad;
		bad = isMisaligned(size, addr[1:0]);
		busAccess(makeCmd(1'b1, size, 1'b0, addr, data), got);
		if (!bad) begin
			model[addr[13:2]] = mergeStore(model[addr[13:2]], size, addr[1:0], data);
		end
		checkResult(got, '{valid: 1'b1, error: bad, readData: 32'h0},
			$sformatf("store %s at %h", size.name(), addr));
	endtask

	task automatic loadFrom(input logic [byteAddrWidth-1:0] addr, input accessSize size,
			input logic uns);
		busResult got;
		busResult exp;
		exp.valid = 1'b1;
		exp.error = isMisaligned(size, addr[1:0]);
		exp.readData = exp.error ? 32'h0 : extendLoad(model[addr[13:2]], size, addr[1:0], uns);
		busAccess(makeCmd(1'b0, size, uns, addr, 32'h0), got);
		checkResult(got, exp, $sformatf("load %s at %h unsigned %b", size.name(), addr, uns));
	endtask

	// pc driven at the start of a fetch slot with valid two cycles later
	task automatic readInstruction(input logic [byteAddrWidth-1:0] addr);
		fetchPort exp;
		@(negedge clk);
		while (!dataSlot) @(negedge clk);
		@(posedge clk);
		pc <= addr;
		repeat (2) @(posedge clk);
		@(negedge clk);
		exp = '{valid: 1'b1, instruction: model[addr[13:2]]};
		checkFetch(fetch, exp, $sformatf("fetch at %h", addr));
		// one-cycle strobe while the instruction is still held
		@(negedge clk);
		exp.valid = 1'b0;
		checkFetch(fetch, exp, $sformatf("fetch hold at %h", addr));
	endtask

	task automatic preloadFetch();
		readInstruction(14'h000);
		readInstruction(14'h004);
		readInstruction(14'h020);
		readInstruction(14'h03c);
	endtask

	task automatic wordRoundTrip();
		storeTo(14'h030, sizeWord, $urandom());
		storeTo(14'h034, sizeWord, $urandom());
		loadFrom(14'h030, sizeWord, 1'b0);
		loadFrom(14'h034, sizeWord, 1'b0);
	endtask

	// one changed lane per word so upper data bits must not leak
	task automatic laneMerge();
		for (int off = 0; off < 4; off++) begin
			storeTo(14'h020 + 14'(5 * off), sizeByte, $urandom());
		end
		storeTo(14'h038, sizeHalf, $urandom());
		storeTo(14'h03e, sizeHalf, $urandom());
		for (int w = 8; w < 12; w++) begin
			loadFrom(14'(4 * w), sizeWord, 1'b0);
		end
		loadFrom(14'h038, sizeWord, 1'b0);
		loadFrom(14'h03c, sizeWord, 1'b0);
	endtask

	// lanes 81, 7f, ff, 80 give both signs at byte and half width
	task automatic loadExtension();
		storeTo(14'h014, sizeWord, 32'h80ff_7f81);
		for (int uns = 0; uns < 2; uns++) begin
			for (int off = 0; off < 4; off++) begin
				loadFrom(14'h014 + 14'(off), sizeByte, uns[0]);
			end
			loadFrom(14'h014, sizeHalf, uns[0]);
			loadFrom(14'h016, sizeHalf, uns[0]);
		end
	endtask

	task automatic misalignedAccess();
		storeTo(14'h019, sizeHalf, $urandom());
		storeTo(14'h01a, sizeWord, $urandom());
		loadFrom(14'h01b, sizeHalf, 1'b0);
		loadFrom(14'h018, sizeWord, 1'b0);
	endtask

	// data store then instruction fetch of the same word
	task automatic unifiedMemory();
		storeTo(14'h00c, sizeWord, $urandom());
		readInstruction(14'h00c);
	endtask

	initial begin
		void'($urandom(17));
		$readmemh(initFile, model);
		reset <= 1'b1;
		pc <= '0;
		cmd <= '0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		checkResult(result, '0, "result after reset");
		if (dataSlot !== 1'b0 || fetch.valid !== 1'b0) begin
			failRun($sformatf("MISMATCH at %0t: slot or fetch strobe set after reset", $time));
		end
		preloadFetch();
		wordRoundTrip();
		laneMerge();
		loadExtension();
		misalignedAccess();
		unifiedMemory();
		$display("RESULT: PASS");
		$finish;
	end

endmodule

// File: program.hex
// one 32-bit word per line, hex, word addresses 0 to 15
00500093
00a00113
002081b3
40110233
0041a023
0001a283
fe5214e3
00c0006f
8badf00d
7f80ff01
12345678
cafe8001
00000013
deadbeef
a5a55a5a
0000006f

// File: runSim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, verdict from the log
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module memorySubsystemTb -f flist.f -o simv

# the log is searched even when the run stops early
./obj_dir/simv | tee sim.log

if grep -q "RESULT: PASS" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// File: storeAligner.sv
`timescale 1ns/1ps

module storeAligner (
	input memBusPkg::accessSize size,
	input logic [1:0] offset,
	input logic write,
	input memBusPkg::memWord storeData,
	output logic [3:0] byteMask,
	output memBusPkg::memWord laneData,
	output logic misaligned
);
	import memBusPkg::*;

	always_comb begin
		laneData = '0;
		byteMask = 4'b0000;
		misaligned = 1'b0;
		unique case (size)
			sizeByte: begin
				// any offset is fine for a byte
				laneData.bytes[offset] = storeData.bytes[0];
				byteMask[offset] = 1'b1;
			end
			sizeHalf: begin
				// low half of storeData into lanes 1:0 or 3:2
				laneData.halves[offset[1]] = storeData.halves[0];
				byteMask = offset[1] ? 4'b1100 : 4'b0011;
				misaligned = offset[0];
			end
			sizeWord: begin
				laneData = storeData;
				byteMask = 4'b1111;
				misaligned = (offset != 2'b00);
			end
			default: begin
				// reserved size code is treated like a bad alignment
				misaligned = 1'b1;
			end
		endcase
		// nothing may be written when misaligned or not a store
		if (!write || misaligned) begin
			byteMask = 4'b0000;
		end
	end

	// mask must be one whole naturally aligned lane group
	always_comb begin
		legalMask: assert (byteMask inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
				4'b0011, 4'b1100, 4'b1111})
			else $error("storeAligner: illegal lane mask %b", byteMask);
	end

endmodule
